// File: vlog.f
+incdir+verilog
verilog/coh_types_pkg.sv
verilog/memory_control.sv
verilog/ram.sv
verilog/coherent_mem_top.sv
verif/coh_chk.sv
verif/coh_scoreboard.sv
verif/tb_coherent_mem.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator and run, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f vlog.f \
  --top-module tb_coherent_mem -o tb_coherent_mem &&
out=$(./obj_dir/tb_coherent_mem) &&
echo "$out" &&
echo "$out" | grep -qx "sim passed" ||
{ echo "simulation did not pass"; exit 1; }

// File: verif/tb_coherent_mem.sv
// clock, reset, cache agents with xorshift stimulus, watchdog and final report
`timescale 1ns/1ps
`include "coh_cfg.svh"

module tb_coherent_mem;
  import coh_types_pkg::*;

  localparam int N_TESTS = 6;

  logic     CLK;
  logic     nRST;
  cpu_req_t cpu_req [2];
  cpu_rsp_t cpu_rsp [2];

  logic [31:0] rng_state;
  // blocks each agent holds in its cache over the 64-word window
  logic        owns [2][64];

  coherent_mem_top u_coherent_mem_top (
    .CLK     (CLK),
    .nRST    (nRST),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp)
  );

  coh_scoreboard u_sb (
    .CLK     (CLK),
    .nRST    (nRST),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp)
  );

  bind memory_control coh_chk u_chk (
    .CLK     (CLK),
    .nRST    (nRST),
    .cpu_rsp (cpu_rsp),
    .ram_req (ram_req),
    .state   (state),
    .snooper (snooper)
  );

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // two-word aligned block address
  function addr_t block_addr();
    logic [31:0] r;
    r = next_rand();
    return {24'd0, r[5:1], 3'b000};
  endfunction

  function addr_t word_addr();
    logic [31:0] r;
    r = next_rand();
    return {24'd0, r[5:0], 2'b00};
  endfunction

  // every task starts and ends 1 ns after a rising edge
  task automatic fetch(input int c, input addr_t a);
    cpu_req[c].iREN  = 1'b1;
    cpu_req[c].iaddr = a;
    do @(posedge CLK); while (cpu_rsp[c].iwait);
    #1;
    cpu_req[c].iREN = 1'b0;
  endtask

  task automatic block_store(input int c, input addr_t a, input word_t d0, input word_t d1);
    cpu_req[c].dWEN   = 1'b1;
    cpu_req[c].daddr  = a;
    cpu_req[c].dstore = d0;
    do @(posedge CLK); while (cpu_rsp[c].dwait);
    #1;
    cpu_req[c].daddr  = a + 4;
    cpu_req[c].dstore = d1;
    do @(posedge CLK); while (cpu_rsp[c].dwait);
    #1;
    cpu_req[c].dWEN = 1'b0;
  endtask

  // snooped agent answers only for blocks it owns
  task automatic answer_snoop(input int o, input word_t s0, input word_t s1, input logic wr);
    addr_t sa;
    do @(posedge CLK); while (!cpu_rsp[o].ccwait);
    sa = cpu_rsp[o].ccsnoopaddr;
    #1;
    if (owns[o][sa[7:2]])
    begin
      cpu_req[o].cctrans = 1'b1;
      cpu_req[o].dstore  = s0;
      do @(posedge CLK); while (cpu_rsp[o].dwait);
      #1;
      cpu_req[o].dstore = s1;
      do @(posedge CLK); while (cpu_rsp[o].dwait);
      #1;
      cpu_req[o].cctrans = 1'b0;
      cpu_req[o].dstore  = '0;
      // write intent by the requester drops our copy
      if (wr)
        owns[o][sa[7:2]] = 1'b0;
    end
  endtask

  task automatic data_read(input int c, input addr_t a, input logic wr,
                           input word_t s0, input word_t s1);
    fork
      begin
        cpu_req[c].dREN    = 1'b1;
        cpu_req[c].ccwrite = wr;
        cpu_req[c].daddr   = a;
        do @(posedge CLK); while (cpu_rsp[c].dwait);
        #1;
        cpu_req[c].daddr = a + 4;
        do @(posedge CLK); while (cpu_rsp[c].dwait);
        #1;
        cpu_req[c].dREN    = 1'b0;
        cpu_req[c].ccwrite = 1'b0;
      end
      answer_snoop(1 - c, s0, s1, wr);
    join
  endtask

  task automatic upgrade(input int c, input addr_t a);
    cpu_req[c].cctrans = 1'b1;
    cpu_req[c].daddr   = a;
    do @(posedge CLK); while (cpu_rsp[c].dwait);
    #1;
    cpu_req[c].cctrans = 1'b0;
  endtask

  task automatic set_owns(input logic v);
    for (int c = 0; c < 2; c++)
      for (int i = 0; i < 64; i++)
        owns[c][i] = v;
  endtask

  // watchdog sized from the test count
  initial
  begin
    repeat (N_TESTS * 40 * (`COH_RAM_LAT + 1)) @(posedge CLK);
    $display("timeout: the tests did not finish within the cycle budget");
    $display("sim failed");
    $finish;
  end

  initial
  begin
    addr_t       a;
    int          c;
    logic [31:0] r;
    logic        wr;
    int          asrt_fails;
    rng_state = 32'd27;
    nRST      = 1'b0;
    for (int i = 0; i < 2; i++)
      cpu_req[i] = '0;
    set_owns(1'b0);
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;

    // quiet outputs checked by the scoreboard every idle cycle
    repeat (5) @(posedge CLK);
    #1;
    u_sb.end_test("reset and idle");

    // lru is still 0 so core 0 wins first
    for (int i = 0; i < 4; i++)
    begin
      fork
        fetch(0, word_addr());
        fetch(1, word_addr());
      join
    end
    u_sb.end_test("fairness");

    for (int i = 0; i < 3; i++)
    begin
      a = block_addr();
      c = int'(next_rand() & 1);
      block_store(c, a, next_rand(), next_rand());
      fetch(1 - c, a);
      fetch(c, a + 4);
      fetch(c, word_addr());
    end
    u_sb.end_test("store then fetch");

    set_owns(1'b0);
    for (int i = 0; i < 3; i++)
    begin
      c = int'(next_rand() & 1);
      data_read(c, block_addr(), 1'b0, '0, '0);
    end
    u_sb.end_test("snoop miss");

    set_owns(1'b1);
    for (int i = 0; i < 3; i++)
    begin
      a  = block_addr();
      c  = int'(next_rand() & 1);
      r  = next_rand();
      wr = r[0];
      data_read(c, a, wr, next_rand(), next_rand());
      // written back so ram now holds the cache data
      fetch(c, a);
      fetch(1 - c, a + 4);
    end
    u_sb.end_test("snoop hit");

    for (int i = 0; i < 3; i++)
    begin
      c = int'(next_rand() & 1);
      upgrade(c, block_addr());
      @(posedge CLK);
      #1;
    end
    u_sb.end_test("upgrade");

    asrt_fails = u_coherent_mem_top.u_memory_control.u_chk.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
      u_sb.test_num, u_sb.check_count, u_sb.err_count, asrt_fails);
    if (u_sb.err_count == 0 && asrt_fails == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: verif/coh_scoreboard.sv
// memory and lru model with completion checks and per-test report
`timescale 1ns/1ps
`include "coh_cfg.svh"

module coh_scoreboard (
  input logic                    CLK,
  input logic                    nRST,
  input coh_types_pkg::cpu_req_t cpu_req [2],
  input coh_types_pkg::cpu_rsp_t cpu_rsp [2]
);
  import coh_types_pkg::*;

  // shadow of ram contents and of the arbitration pointer
  word_t model [`COH_MEM_DEPTH];
  logic  lru_m;
  int    st_words [2];
  int    rd_words [2];
  logic  saw_ccwait [2];

  int err_count;
  int check_count;
  int test_errs;
  int test_num;

  task automatic check_word(input string what, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      test_errs++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic ok);
    check_count++;
    if (ok !== 1'b1)
    begin
      err_count++;
      test_errs++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // called by the testbench when a test has run
  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, test_errs);
    test_errs = 0;
  endtask

  always @(posedge CLK)
  begin
    logic idle;
    int   o;
    if (!nRST)
    begin
      for (int i = 0; i < `COH_MEM_DEPTH; i++)
        model[i] = '0;
      lru_m = 1'b0;
      for (int i = 0; i < 2; i++)
      begin
        st_words[i]   = 0;
        rd_words[i]   = 0;
        saw_ccwait[i] = 1'b0;
      end
    end
    else
    begin
      idle = 1'b1;
      for (int c = 0; c < 2; c++)
        if (cpu_req[c].iREN || cpu_req[c].dREN || cpu_req[c].dWEN || cpu_req[c].cctrans)
          idle = 1'b0;
      // nothing asked means nothing granted or snooped
      if (idle)
        for (int c = 0; c < 2; c++)
          check_flag("outputs not quiet while idle",
            cpu_rsp[c].iwait && cpu_rsp[c].dwait && !cpu_rsp[c].ccwait && !cpu_rsp[c].ccinv);

      for (int c = 0; c < 2; c++)
      begin
        o = 1 - c;
        if (cpu_req[c].dREN && cpu_rsp[o].ccwait && !saw_ccwait[c])
        begin
          // first snoop cycle names the wanted block
          check_word("ccsnoopaddr on snoop", cpu_rsp[o].ccsnoopaddr, cpu_req[c].daddr);
          saw_ccwait[c] = 1'b1;
        end

        // fetch word done
        if (cpu_req[c].iREN && !cpu_rsp[c].iwait)
        begin
          if (cpu_req[o].iREN)
            check_flag("fetch granted against lru order", c == int'(lru_m));
          check_word("iload", cpu_rsp[c].iload, model[cpu_req[c].iaddr[9:2]]);
          lru_m = (c == 0);
        end

        // one word of a block writeback
        if (cpu_req[c].dWEN && !cpu_rsp[c].dwait)
        begin
          model[cpu_req[c].daddr[9:2]] = cpu_req[c].dstore;
          st_words[c]++;
          if (st_words[c] == 2)
          begin
            st_words[c] = 0;
            lru_m       = (c == 0);
          end
        end

        // read word where both waits low mean the other cache supplied it
        if (cpu_req[c].dREN && !cpu_rsp[c].dwait)
        begin
          if (!cpu_rsp[o].dwait)
          begin
            check_word("dload from cache", cpu_rsp[c].dload, cpu_req[o].dstore);
            check_flag("ccinv does not follow ccwrite",
              cpu_rsp[o].ccinv == cpu_req[c].ccwrite);
            model[cpu_req[c].daddr[9:2]] = cpu_req[o].dstore;
          end
          else
          begin
            check_flag("other core was never snooped", saw_ccwait[c]);
            check_word("dload from ram", cpu_rsp[c].dload, model[cpu_req[c].daddr[9:2]]);
          end
          rd_words[c]++;
          if (rd_words[c] == 2)
          begin
            rd_words[c]   = 0;
            saw_ccwait[c] = 1'b0;
            lru_m         = (c == 0);
          end
        end

        // s to m upgrade released alone
        if (cpu_req[c].cctrans && !cpu_req[c].dREN && !cpu_req[c].dWEN
            && !cpu_rsp[c].dwait && cpu_rsp[o].dwait)
        begin
          check_flag("upgrade without ccinv to other core", cpu_rsp[o].ccinv);
          check_word("ccsnoopaddr on upgrade", cpu_rsp[o].ccsnoopaddr, cpu_req[c].daddr);
          lru_m = (c == 0);
        end
      end
    end
  end

endmodule

// File: verif/coh_chk.sv
// bound assertions on the coherence controller outputs
`timescale 1ns/1ps

module coh_chk (
  input logic                    CLK,
  input logic                    nRST,
  input coh_types_pkg::cpu_rsp_t cpu_rsp [2],
  input coh_types_pkg::ram_req_t ram_req,
  input logic [3:0]              state,
  input logic                    snooper
);
  import coh_types_pkg::*;

  // encodings of the two cache to cache states
  localparam logic [3:0] CACHE_1_ST = 4'd6;
  localparam logic [3:0] CACHE_2_ST = 4'd7;

  logic in_cache;
  logic [3:0] waits_low;
  // failed assertions, read by the testbench at the end
  int fail_count = 0;

  assign in_cache  = (state == CACHE_1_ST) || (state == CACHE_2_ST);
  assign waits_low = ~{cpu_rsp[0].iwait, cpu_rsp[0].dwait, cpu_rsp[1].iwait, cpu_rsp[1].dwait};

  // ram gets a read or a write but never both
  a_ram_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram_req.ramREN && ram_req.ramWEN))
    else
    begin
      $error("ram read and write requested together");
      fail_count++;
    end

  // single completion per cycle outside cache transfers
  a_one_done: assert property (@(posedge CLK) disable iff (!nRST)
    in_cache || ($countones(waits_low) <= 1))
    else
    begin
      $error("more than one wait low outside a cache transfer");
      fail_count++;
    end

  // requester of a cache transfer is never invalidated
  a_no_self_inv: assert property (@(posedge CLK) disable iff (!nRST)
    !(in_cache && cpu_rsp[snooper].ccinv))
    else
    begin
      $error("ccinv sent to the requesting core");
      fail_count++;
    end

  // invalidation targets one core at a time
  a_one_inv: assert property (@(posedge CLK) disable iff (!nRST)
    !(cpu_rsp[0].ccinv && cpu_rsp[1].ccinv))
    else
    begin
      $error("ccinv sent to both cores");
      fail_count++;
    end

endmodule

// File: verilog/coherent_mem_top.sv
// coherence controller joined to the latency ram
`timescale 1ns/1ps

module coherent_mem_top (
  input  logic                    CLK,
  input  logic                    nRST,
  input  coh_types_pkg::cpu_req_t cpu_req [2],
  output coh_types_pkg::cpu_rsp_t cpu_rsp [2]
);
  import coh_types_pkg::*;

  // controller to ram and back
  ram_req_t ram_req;
  ram_rsp_t ram_rsp;

  // arbitration and snooping for both cores
  memory_control u_memory_control (
    .CLK     (CLK),
    .nRST    (nRST),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

  // shared backing store
  ram u_ram (
    .CLK     (CLK),
    .nRST    (nRST),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

endmodule

// File: verilog/ram.sv
// word-addressed memory with fixed latency counter and ramstate reporting
`timescale 1ns/1ps
`include "coh_cfg.svh"

module ram (
  input  logic                    CLK,
  input  logic                    nRST,
  input  coh_types_pkg::ram_req_t ram_req,
  output coh_types_pkg::ram_rsp_t ram_rsp
);
  import coh_types_pkg::*;

  localparam int DEPTH = `COH_MEM_DEPTH;
  localparam int LAT   = `COH_RAM_LAT;
  localparam int IDX_W = $clog2(DEPTH);
  // counter wide enough to reach LAT and never narrower than one bit
  localparam int CNT_W = (LAT > 0) ? $clog2(LAT + 1) : 1;
  localparam logic [CNT_W-1:0] LAT_C = CNT_W'(LAT);

  word_t mem [DEPTH];

  logic [CNT_W-1:0] cnt;
  logic             active;
  logic             in_range;
  logic [IDX_W-1:0] idx;

  assign active = ram_req.ramREN | ram_req.ramWEN;

  // word index starts at bit 2 of the byte address
  assign idx      = ram_req.ramaddr[IDX_W+1:2];
  assign in_range = (ram_req.ramaddr[`COH_ADDR_W-1:2] < DEPTH);

  // free with no request, busy while counting, then one access cycle
  always_comb
  begin
    if (!active)
      ram_rsp.ramstate = FREE;
    else if (cnt != LAT_C)
      ram_rsp.ramstate = BUSY;
    else if (in_range)
      ram_rsp.ramstate = ACCESS;
    else
      ram_rsp.ramstate = ERROR;
  end

  // read data only shown on the access cycle
  assign ram_rsp.ramload = (ram_req.ramREN && ram_rsp.ramstate == ACCESS) ? mem[idx] : '0;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      cnt <= '0;
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;
    end
    else
    begin
      // restart after access so a held request starts a new word
      if (!active || cnt == LAT_C)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;

      if (ram_req.ramWEN && ram_rsp.ramstate == ACCESS)
        mem[idx] <= ram_req.ramstore;
    end
  end

endmodule

// File: verilog/memory_control.sv
// two-core arbitration and msi snoop state machine in front of the ram
`timescale 1ns/1ps

module memory_control (
  input  logic                    CLK,
  input  logic                    nRST,
  input  coh_types_pkg::cpu_req_t cpu_req [2],
  output coh_types_pkg::cpu_rsp_t cpu_rsp [2],
  output coh_types_pkg::ram_req_t ram_req,
  input  coh_types_pkg::ram_rsp_t ram_rsp
);
  import coh_types_pkg::*;

  typedef enum logic [3:0]
  {
    IDLE,
    INSTRUCTION,
    ARBITRATE,
    STORE_1,
    STORE_2,
    SNOOP,
    CACHE_1,
    CACHE_2,
    LOAD_1,
    LOAD_2
  } state_t;

  state_t state, next_state;

  // lru points at the core preferred next
  logic lru, next_lru;
  // requester of the current read whose partner gets snooped
  logic snooper, next_snooper;
  logic snoopy;

  // one word finished at the ram this cycle
  logic done;

  // winners per request kind with the lru core first
  logic ipick, spick, rpick, upick;
  logic any_iren, any_dwen, any_dren, any_trans;

  assign snoopy = ~snooper;
  assign done   = (ram_rsp.ramstate == ACCESS);

  assign any_iren  = cpu_req[0].iREN | cpu_req[1].iREN;
  assign any_dwen  = cpu_req[0].dWEN | cpu_req[1].dWEN;
  assign any_dren  = cpu_req[0].dREN | cpu_req[1].dREN;
  assign any_trans = cpu_req[0].cctrans | cpu_req[1].cctrans;

  assign ipick = cpu_req[lru].iREN    ? lru : ~lru;
  assign spick = cpu_req[lru].dWEN    ? lru : ~lru;
  assign rpick = cpu_req[lru].dREN    ? lru : ~lru;
  assign upick = cpu_req[lru].cctrans ? lru : ~lru;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state   <= IDLE;
      lru     <= 1'b0;
      snooper <= 1'b0;
    end
    else
    begin
      state   <= next_state;
      lru     <= next_lru;
      snooper <= next_snooper;
    end
  end

  // next state
  always_comb
  begin
    next_state   = state;
    next_snooper = snooper;

    case (state)
      IDLE:
      begin
        // writebacks first, then coherence traffic, then fetches
        if (any_dwen)
          next_state = STORE_1;
        else if (any_trans || any_dren)
          next_state = ARBITRATE;
        else if (any_iren)
          next_state = INSTRUCTION;
      end

      INSTRUCTION:
      begin
        if (done)
          next_state = IDLE;
      end

      STORE_1:
      begin
        if (done)
          next_state = STORE_2;
      end

      STORE_2:
      begin
        if (done)
          next_state = IDLE;
      end

      ARBITRATE:
      begin
        // a read goes on to snoop while a bare upgrade ends here
        if (any_dren)
        begin
          next_state   = SNOOP;
          next_snooper = rpick;
        end
        else
        begin
          next_state = IDLE;
        end
      end

      SNOOP:
      begin
        // cctrans from the snooped core means it holds the block
        if (cpu_req[snoopy].cctrans)
          next_state = CACHE_1;
        else
          next_state = LOAD_1;
      end

      CACHE_1:
      begin
        if (done)
          next_state = CACHE_2;
      end

      CACHE_2:
      begin
        if (done)
          next_state = IDLE;
      end

      LOAD_1:
      begin
        if (done)
          next_state = LOAD_2;
      end

      LOAD_2:
      begin
        if (done)
          next_state = IDLE;
      end

      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  // outputs and lru update
  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      cpu_rsp[i].iwait       = 1'b1;
      cpu_rsp[i].iload       = '0;
      cpu_rsp[i].dwait       = 1'b1;
      cpu_rsp[i].dload       = '0;
      cpu_rsp[i].ccwait      = 1'b0;
      cpu_rsp[i].ccinv       = 1'b0;
      cpu_rsp[i].ccsnoopaddr = '0;
    end
    ram_req  = '0;
    next_lru = lru;

    case (state)
      INSTRUCTION:
      begin
        ram_req.ramREN       = any_iren;
        ram_req.ramaddr      = cpu_req[ipick].iaddr;
        cpu_rsp[ipick].iload = ram_rsp.ramload;
        if (done && any_iren)
        begin
          cpu_rsp[ipick].iwait = 1'b0;
          next_lru             = ~ipick;
        end
      end

      STORE_1, STORE_2:
      begin
        // two-word writeback with daddr stepped by the core between words
        ram_req.ramWEN   = any_dwen;
        ram_req.ramaddr  = cpu_req[spick].daddr;
        ram_req.ramstore = cpu_req[spick].dstore;
        if (done && any_dwen)
        begin
          cpu_rsp[spick].dwait = 1'b0;
          if (state == STORE_2)
            next_lru = ~spick;
        end
      end

      ARBITRATE:
      begin
        if (any_dren)
        begin
          // freeze the other core and show it the wanted block
          cpu_rsp[~rpick].ccwait      = 1'b1;
          cpu_rsp[~rpick].ccsnoopaddr = cpu_req[rpick].daddr;
        end
        else if (any_trans)
        begin
          // s to m upgrade kills the other copy and releases the core now
          cpu_rsp[~upick].ccinv       = 1'b1;
          cpu_rsp[~upick].ccsnoopaddr = cpu_req[upick].daddr;
          cpu_rsp[upick].dwait        = 1'b0;
          next_lru                    = ~upick;
        end
      end

      SNOOP:
      begin
        cpu_rsp[snoopy].ccwait      = 1'b1;
        cpu_rsp[snoopy].ccsnoopaddr = cpu_req[snooper].daddr;
      end

      CACHE_1, CACHE_2:
      begin
        // cache to cache transfer with the same word written back to ram
        cpu_rsp[snoopy].ccwait      = 1'b1;
        cpu_rsp[snoopy].ccsnoopaddr = cpu_req[snooper].daddr;
        cpu_rsp[snooper].dload      = cpu_req[snoopy].dstore;
        // requester writing means the supplier must drop its line
        cpu_rsp[snoopy].ccinv       = cpu_req[snooper].ccwrite;
        ram_req.ramWEN              = 1'b1;
        ram_req.ramaddr             = cpu_req[snooper].daddr;
        ram_req.ramstore            = cpu_req[snoopy].dstore;
        if (done)
        begin
          // both cores step to the next word together
          cpu_rsp[snooper].dwait = 1'b0;
          cpu_rsp[snoopy].dwait  = 1'b0;
          if (state == CACHE_2)
            next_lru = ~snooper;
        end
      end

      LOAD_1, LOAD_2:
      begin
        // snoop missed so the block comes from ram
        cpu_rsp[snoopy].ccwait = 1'b1;
        ram_req.ramREN         = 1'b1;
        ram_req.ramaddr        = cpu_req[snooper].daddr;
        cpu_rsp[snooper].dload = ram_rsp.ramload;
        if (done)
        begin
          cpu_rsp[snooper].dwait = 1'b0;
          if (state == LOAD_2)
            next_lru = ~snooper;
        end
      end

      default:
      begin
      end
    endcase
  end

endmodule

// File: verilog/coh_types_pkg.sv
// word, address and ramstate types with the core and ram request and response structs
`include "coh_cfg.svh"

package coh_types_pkg;

  // basic data and address words
  typedef logic [`COH_WORD_W-1:0] word_t;
  typedef logic [`COH_ADDR_W-1:0] addr_t;

  // ram progress as seen by the controller
  typedef enum logic [1:0]
  {
    FREE,
    BUSY,
    ACCESS,
    ERROR
  } ramstate_t;

  // one core toward the controller with the ifetch side first
  typedef struct packed {
    logic  iREN;
    addr_t iaddr;
    logic  dREN;
    logic  dWEN;
    addr_t daddr;
    word_t dstore;
    // msi transition strobe and write intent
    logic  cctrans;
    logic  ccwrite;
  } cpu_req_t;

  // controller back to one core
  typedef struct packed {
    logic  iwait;
    word_t iload;
    logic  dwait;
    word_t dload;
    // snoop side as plain levels
    logic  ccwait;
    logic  ccinv;
    addr_t ccsnoopaddr;
  } cpu_rsp_t;

  // controller toward ram
  typedef struct packed {
    logic  ramREN;
    logic  ramWEN;
    addr_t ramaddr;
    word_t ramstore;
  } ram_req_t;

  // ram answer
  typedef struct packed {
    word_t     ramload;
    ramstate_t ramstate;
  } ram_rsp_t;

endpackage

// File: verilog/coh_cfg.svh
// ram latency, memory depth, address width and word width macros
`ifndef COH_CFG_SVH
`define COH_CFG_SVH

// busy cycles the ram spends before its access cycle
`define COH_RAM_LAT 2

// words held by the ram array
`define COH_MEM_DEPTH 256

// byte address width on every port
`define COH_ADDR_W 32

// data word width
`define COH_WORD_W 32

`endif
